/* hdl/lvds_rx_defines.svh */
// lvds rx defines: word geometry and alignment search constants for the 7:1 receiver
`ifndef LVDS_RX_DEFINES_SVH
`define LVDS_RX_DEFINES_SVH

// --------------------
// lane geometry
// --------------------

// bits per deserialized lane word, one pixel clock
`define LVDS_WORD_BITS 7

// data lanes per channel, clock lane not counted
`define LVDS_DATA_LANES 4

// bits per colour component in the unpacked pixel
`define LVDS_COLOR_BITS 8

// --------------------
// word alignment
// --------------------

// clock lane word once the boundary is right
`define LVDS_CLOCK_PATTERN 7'b1100011

// back-to-back matches needed before word lock
`define LVDS_LOCK_COUNT 4

// idle cycles after each rotation step
`define LVDS_SLIP_WAIT 2

`endif

/* hdl/lvds_rx_pkg.sv */
// lvds rx package: lane, pixel and sync types shared by the receiver back end
`include "lvds_rx_defines.svh"
`default_nettype none

package lvds_rx_pkg;

    // --------------------
    // lane words
    // --------------------
    typedef logic [`LVDS_WORD_BITS-1:0] lane_word_t;

    typedef struct packed {
        lane_word_t lane0;
        lane_word_t lane1;
        lane_word_t lane2;  // also carries de, vs, hs
        lane_word_t lane3;  // colour extension bits
    } channel_lanes_t;

    typedef logic [2:0] rotation_t;  // 0 to 6

    typedef struct packed {
        logic           locked;  // word_lock one stage later
        channel_lanes_t odd;
        channel_lanes_t even;
    } aligned_lanes_t;

    // --------------------
    // video out
    // --------------------
    typedef struct packed {
        logic [`LVDS_COLOR_BITS-1:0] r;
        logic [`LVDS_COLOR_BITS-1:0] g;
        logic [`LVDS_COLOR_BITS-1:0] b;
    } rgb_pixel_t;

    typedef struct packed {
        logic vs;
        logic hs;
        logic de;
    } video_sync_t;

    // where the lane3 extension pair lands
    typedef enum logic {
        MAP_VESA  = 1'b0,  // extension bits on top
        MAP_JEIDA = 1'b1   // extension bits at the bottom
    } map_mode_t;

    // rotate left inside one lane word, bit i goes to (i + amount) mod 7
    function automatic lane_word_t rotate_word(lane_word_t word, rotation_t amount);
        lane_word_t  result;
        int unsigned dst;
        result = '0;
        for (int unsigned i = 0; i < `LVDS_WORD_BITS; i++)
        begin
            dst = i + amount;
            if (dst >= `LVDS_WORD_BITS)
                dst = dst - `LVDS_WORD_BITS;
            result[dst] = word[i];
        end
        return result;
    endfunction

endpackage

`default_nettype wire

/* hdl/word_align_ctl.sv */
// word_align_ctl: qualifies the lock flags and searches the clock lane for the word boundary
`include "lvds_rx_defines.svh"
`default_nettype none

module word_align_ctl (
    input  logic                    O_pix_clk,
    input  logic                    reset_sync,
    input  logic                    pll_lock,
    input  logic                    phase_lock,
    input  lvds_rx_pkg::lane_word_t clk_word,
    output lvds_rx_pkg::rotation_t  rotation,
    output logic                    word_lock
);

    localparam int MATCH_W = $clog2(`LVDS_LOCK_COUNT + 1);
    localparam int WAIT_W  = $clog2(`LVDS_SLIP_WAIT + 1);

    localparam logic [MATCH_W-1:0] LOCK_COUNT = MATCH_W'(`LVDS_LOCK_COUNT);
    localparam logic [WAIT_W-1:0]  SLIP_WAIT  = WAIT_W'(`LVDS_SLIP_WAIT);

    localparam lvds_rx_pkg::lane_word_t CLOCK_PATTERN = `LVDS_CLOCK_PATTERN;
    localparam lvds_rx_pkg::rotation_t  LAST_ROT =
        lvds_rx_pkg::rotation_t'(`LVDS_WORD_BITS - 1);

    logic               lock_d1;
    logic               align_enable;
    logic [MATCH_W-1:0] match_cnt;
    logic [WAIT_W-1:0]  wait_cnt;
    logic               compare_en;
    logic               pattern_hit;

    // --------------------
    // lock qualification
    // --------------------

    // two stage pipe on the combined pll and phase lock
    always_ff @(posedge O_pix_clk or posedge reset_sync)
    begin
        if (reset_sync)
        begin
            lock_d1      <= 1'b0;
            align_enable <= 1'b0;
        end
        else
        begin
            lock_d1      <= pll_lock && phase_lock;
            align_enable <= lock_d1;
        end
    end

    // --------------------
    // pattern search
    // --------------------

    // compare only when searching and not settling after a slip
    assign compare_en  = align_enable && !word_lock && (wait_cnt == '0);
    assign pattern_hit = (lvds_rx_pkg::rotate_word(clk_word, rotation) == CLOCK_PATTERN);

    always_ff @(posedge O_pix_clk or posedge reset_sync)
    begin
        if (reset_sync)
        begin
            rotation  <= '0;
            word_lock <= 1'b0;
            match_cnt <= '0;
            wait_cnt  <= '0;
        end
        else if (!align_enable)
        begin
            // lost lock upstream, start over from rotation 0
            rotation  <= '0;
            word_lock <= 1'b0;
            match_cnt <= '0;
            wait_cnt  <= '0;
        end
        else
        begin
            if (wait_cnt != '0)
                wait_cnt <= wait_cnt - 1'b1;

            if (compare_en)
            begin
                if (pattern_hit)
                begin
                    match_cnt <= match_cnt + 1'b1;
                    if (match_cnt + 1'b1 == LOCK_COUNT)
                        word_lock <= 1'b1;  // rotation frozen from here
                end
                else
                begin
                    // wrong boundary, step one bit and let it settle
                    match_cnt <= '0;
                    rotation  <= (rotation == LAST_ROT) ? '0 : rotation + 1'b1;
                    wait_cnt  <= SLIP_WAIT;
                end
            end
        end
    end

    // --------------------
    // checks
    // --------------------

    // rotation wraps after 6, never reaches 7
    assert property (@(posedge O_pix_clk) disable iff (reset_sync)
        rotation <= LAST_ROT);

    // no lock can follow a cycle without align_enable
    assert property (@(posedge O_pix_clk) disable iff (reset_sync)
        !align_enable |=> !word_lock);

endmodule

`default_nettype wire

/* hdl/lane_derotate.sv */
// lane_derotate: one register stage that rotates all eight data lanes by the found amount
`default_nettype none

module lane_derotate (
    input  logic                        O_pix_clk,
    input  logic                        reset_sync,
    input  lvds_rx_pkg::channel_lanes_t lanes_odd,
    input  lvds_rx_pkg::channel_lanes_t lanes_even,
    input  lvds_rx_pkg::rotation_t      rotation,
    input  logic                        word_lock,
    output lvds_rx_pkg::aligned_lanes_t aligned
);

    // same amount on every lane of one channel
    function automatic lvds_rx_pkg::channel_lanes_t rotate_channel(
        input lvds_rx_pkg::channel_lanes_t lanes,
        input lvds_rx_pkg::rotation_t      amount
    );
        lvds_rx_pkg::channel_lanes_t result;
        result.lane0 = lvds_rx_pkg::rotate_word(lanes.lane0, amount);
        result.lane1 = lvds_rx_pkg::rotate_word(lanes.lane1, amount);
        result.lane2 = lvds_rx_pkg::rotate_word(lanes.lane2, amount);
        result.lane3 = lvds_rx_pkg::rotate_word(lanes.lane3, amount);
        return result;
    endfunction

    // --------------------
    // derotation stage
    // --------------------

    // lock flag rides with the data so downstream gating lines up
    always_ff @(posedge O_pix_clk or posedge reset_sync)
    begin
        if (reset_sync)
        begin
            aligned <= '0;
        end
        else
        begin
            aligned.locked <= word_lock;
            aligned.odd    <= rotate_channel(lanes_odd, rotation);
            aligned.even   <= rotate_channel(lanes_even, rotation);
        end
    end

endmodule

`default_nettype wire

/* hdl/pixel_unpack.sv */
// pixel_unpack: maps one channel's aligned lanes to an rgb888 pixel, vesa or jeida order
`include "lvds_rx_defines.svh"
`default_nettype none

module pixel_unpack (
    input  logic                        O_pix_clk,
    input  logic                        reset_sync,
    input  lvds_rx_pkg::channel_lanes_t lanes,
    input  logic                        locked,
    input  lvds_rx_pkg::map_mode_t      map_mode,
    output lvds_rx_pkg::rgb_pixel_t     pixel
);

    localparam int CORE_W = `LVDS_COLOR_BITS - 2;  // bits carried on lanes 0 to 2

    logic [CORE_W-1:0]       r_core;
    logic [CORE_W-1:0]       g_core;
    logic [CORE_W-1:0]       b_core;
    logic [1:0]              r_ext;
    logic [1:0]              g_ext;
    logic [1:0]              b_ext;
    lvds_rx_pkg::rgb_pixel_t pixel_next;

    // --------------------
    // bit extraction
    // --------------------

    // core bits, msb first
    assign r_core = {lanes.lane0[1], lanes.lane0[2], lanes.lane0[3],
                     lanes.lane0[4], lanes.lane0[5], lanes.lane0[6]};
    assign g_core = {lanes.lane1[2], lanes.lane1[3], lanes.lane1[4],
                     lanes.lane1[5], lanes.lane1[6], lanes.lane0[0]};
    assign b_core = {lanes.lane2[3], lanes.lane2[4], lanes.lane2[5],
                     lanes.lane2[6], lanes.lane1[0], lanes.lane1[1]};

    // extension pairs, all on lane3
    assign r_ext = {lanes.lane3[5], lanes.lane3[6]};
    assign g_ext = {lanes.lane3[3], lanes.lane3[4]};
    assign b_ext = {lanes.lane3[1], lanes.lane3[2]};

    always_comb
    begin
        if (map_mode == lvds_rx_pkg::MAP_JEIDA)
        begin
            pixel_next.r = {r_core, r_ext};
            pixel_next.g = {g_core, g_ext};
            pixel_next.b = {b_core, b_ext};
        end
        else
        begin
            // vesa puts the extension pair on top
            pixel_next.r = {r_ext, r_core};
            pixel_next.g = {g_ext, g_core};
            pixel_next.b = {b_ext, b_core};
        end
    end

    // --------------------
    // output register
    // --------------------

    always_ff @(posedge O_pix_clk or posedge reset_sync)
    begin
        if (reset_sync)
            pixel <= '0;
        else if (locked)
            pixel <= pixel_next;
        else
            pixel <= '0;  // blank until word lock
    end

    // an unlocked input cycle always yields a black pixel
    assert property (@(posedge O_pix_clk) disable iff (reset_sync)
        !locked |=> (pixel == '0));

endmodule

`default_nettype wire

/* hdl/lvds_rx_top.sv */
// lvds_rx_top: two channel 7:1 lvds receiver back end, word alignment to rgb888 plus sync
`default_nettype none

module lvds_rx_top (
    input  logic                        O_pix_clk,
    input  logic                        reset_sync,
    input  logic                        pll_lock,
    input  logic                        phase_lock,
    input  lvds_rx_pkg::map_mode_t      map_mode,
    input  lvds_rx_pkg::lane_word_t     clk_word,
    input  lvds_rx_pkg::channel_lanes_t lanes_odd,
    input  lvds_rx_pkg::channel_lanes_t lanes_even,
    output lvds_rx_pkg::rgb_pixel_t     pixel_odd,
    output lvds_rx_pkg::rgb_pixel_t     pixel_even,
    output lvds_rx_pkg::video_sync_t    sync,
    output logic                        word_lock,
    output lvds_rx_pkg::rotation_t      rotation
);

    lvds_rx_pkg::aligned_lanes_t aligned;

    // --------------------
    // alignment
    // --------------------

    // finds 1100011 on the clock lane
    word_align_ctl u_word_align (
        .O_pix_clk  (O_pix_clk),
        .reset_sync (reset_sync),
        .pll_lock   (pll_lock),
        .phase_lock (phase_lock),
        .clk_word   (clk_word),
        .rotation   (rotation),
        .word_lock  (word_lock)
    );

    lane_derotate u_derotate (
        .O_pix_clk  (O_pix_clk),
        .reset_sync (reset_sync),
        .lanes_odd  (lanes_odd),
        .lanes_even (lanes_even),
        .rotation   (rotation),
        .word_lock  (word_lock),
        .aligned    (aligned)
    );

    // --------------------
    // pixel unpack
    // --------------------

    pixel_unpack u_unpack_odd (
        .O_pix_clk  (O_pix_clk),
        .reset_sync (reset_sync),
        .lanes      (aligned.odd),
        .locked     (aligned.locked),
        .map_mode   (map_mode),
        .pixel      (pixel_odd)
    );

    pixel_unpack u_unpack_even (
        .O_pix_clk  (O_pix_clk),
        .reset_sync (reset_sync),
        .lanes      (aligned.even),
        .locked     (aligned.locked),
        .map_mode   (map_mode),
        .pixel      (pixel_even)
    );

    // --------------------
    // sync extraction
    // --------------------

    // de, vs, hs sit in the low bits of the even channel's lane2
    always_ff @(posedge O_pix_clk or posedge reset_sync)
    begin
        if (reset_sync)
        begin
            sync <= '0;
        end
        else if (aligned.locked)
        begin
            sync.de <= aligned.even.lane2[0];
            sync.vs <= aligned.even.lane2[1];
            sync.hs <= aligned.even.lane2[2];
        end
        else
        begin
            sync <= '0;  // same gating as the pixels
        end
    end

endmodule

`default_nettype wire

/* dv/lvds_rx_tb.sv */
// lvds_rx_tb: random pixel streams at every word skew through the lvds receiver back end
`include "lvds_rx_defines.svh"
`default_nettype none

module lvds_rx_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LOCK_BOUND  = 2 + `LVDS_WORD_BITS * (`LVDS_SLIP_WAIT + 1)
                                 + `LVDS_LOCK_COUNT + 1;
    localparam int DATA_CYCLES = 40;  // per skew and mode

    typedef enum logic [1:0] {CHK_NONE, CHK_ZERO, CHK_REF} check_mode_t;
    typedef enum logic [1:0] {W_LOCK, W_UNLOCK, W_BLANK} wait_cond_t;

    typedef struct packed {
        logic                     check;
        lvds_rx_pkg::rgb_pixel_t  odd;
        lvds_rx_pkg::rgb_pixel_t  even;
        lvds_rx_pkg::video_sync_t sync;
    } expect_t;

    logic                        O_pix_clk;
    logic                        reset_sync;
    logic                        pll_lock;
    logic                        phase_lock;
    lvds_rx_pkg::map_mode_t      map_mode;
    lvds_rx_pkg::lane_word_t     clk_word;
    lvds_rx_pkg::channel_lanes_t lanes_odd;
    lvds_rx_pkg::channel_lanes_t lanes_even;
    lvds_rx_pkg::rgb_pixel_t     pixel_odd;
    lvds_rx_pkg::rgb_pixel_t     pixel_even;
    lvds_rx_pkg::video_sync_t    sync;
    logic                        word_lock;
    lvds_rx_pkg::rotation_t      rotation;

    check_mode_t check_mode;
    int          skew;
    int          checks;
    int          errors;
    int          timeouts;
    int          cmp_checks;
    int          cmp_errors;
    expect_t     exp_q[$];  // one entry per driven cycle

    lvds_rx_top i_dut (
        .O_pix_clk  (O_pix_clk),
        .reset_sync (reset_sync),
        .pll_lock   (pll_lock),
        .phase_lock (phase_lock),
        .map_mode   (map_mode),
        .clk_word   (clk_word),
        .lanes_odd  (lanes_odd),
        .lanes_even (lanes_even),
        .pixel_odd  (pixel_odd),
        .pixel_even (pixel_even),
        .sync       (sync),
        .word_lock  (word_lock),
        .rotation   (rotation)
    );

    always #2 O_pix_clk = ~O_pix_clk;

    // --------------------
    // lane packing
    // --------------------

    function automatic lvds_rx_pkg::lane_word_t rotate_right(
        input lvds_rx_pkg::lane_word_t word,
        input int                      k
    );
        lvds_rx_pkg::lane_word_t res;
        for (int i = 0; i < `LVDS_WORD_BITS; i++)
            res[(i + `LVDS_WORD_BITS - k) % `LVDS_WORD_BITS] = word[i];
        return res;
    endfunction

    function automatic lvds_rx_pkg::channel_lanes_t skew_channel(
        input lvds_rx_pkg::channel_lanes_t ch,
        input int                          k
    );
        lvds_rx_pkg::channel_lanes_t res;
        res.lane0 = rotate_right(ch.lane0, k);
        res.lane1 = rotate_right(ch.lane1, k);
        res.lane2 = rotate_right(ch.lane2, k);
        res.lane3 = rotate_right(ch.lane3, k);
        return res;
    endfunction

    // inverse of the colour mapping with the spare bit on lane3 bit 0
    function automatic lvds_rx_pkg::channel_lanes_t pack_channel(
        input lvds_rx_pkg::rgb_pixel_t  px,
        input lvds_rx_pkg::video_sync_t sy,
        input lvds_rx_pkg::map_mode_t   mode,
        input logic                     spare
    );
        lvds_rx_pkg::channel_lanes_t ch;
        logic [5:0]                  rc;
        logic [5:0]                  gc;
        logic [5:0]                  bc;
        logic [1:0]                  re;
        logic [1:0]                  ge;
        logic [1:0]                  be;
        if (mode == lvds_rx_pkg::MAP_VESA)
        begin
            {re, rc} = px.r;
            {ge, gc} = px.g;
            {be, bc} = px.b;
        end
        else
        begin
            {rc, re} = px.r;
            {gc, ge} = px.g;
            {bc, be} = px.b;
        end
        for (int j = 0; j < 6; j++)
            ch.lane0[1+j] = rc[5-j];
        ch.lane0[0] = gc[0];
        for (int j = 0; j < 5; j++)
            ch.lane1[2+j] = gc[5-j];
        ch.lane1[1] = bc[0];
        ch.lane1[0] = bc[1];
        for (int j = 0; j < 4; j++)
            ch.lane2[3+j] = bc[5-j];
        ch.lane2[2:0] = {sy.hs, sy.vs, sy.de};
        ch.lane3 = {re[0], re[1], ge[0], ge[1], be[0], be[1], spare};
        return ch;
    endfunction

    // --------------------
    // reference model
    // --------------------

    function automatic lvds_rx_pkg::rgb_pixel_t unpack_ref(
        input lvds_rx_pkg::channel_lanes_t ch,
        input lvds_rx_pkg::map_mode_t      mode
    );
        lvds_rx_pkg::rgb_pixel_t px;
        logic [5:0]              rc;
        logic [5:0]              gc;
        logic [5:0]              bc;
        logic [1:0]              re;
        logic [1:0]              ge;
        logic [1:0]              be;
        for (int j = 0; j < 6; j++)
            rc[5-j] = ch.lane0[1+j];
        for (int j = 0; j < 5; j++)
            gc[5-j] = ch.lane1[2+j];
        gc[0] = ch.lane0[0];
        for (int j = 0; j < 4; j++)
            bc[5-j] = ch.lane2[3+j];
        bc[1] = ch.lane1[0];
        bc[0] = ch.lane1[1];
        re = {ch.lane3[5], ch.lane3[6]};
        ge = {ch.lane3[3], ch.lane3[4]};
        be = {ch.lane3[1], ch.lane3[2]};
        if (mode == lvds_rx_pkg::MAP_VESA)
            px = {re, rc, ge, gc, be, bc};  // extension pair on top
        else
            px = {rc, re, gc, ge, bc, be};
        return px;
    endfunction

    function automatic lvds_rx_pkg::video_sync_t sync_ref(input lvds_rx_pkg::channel_lanes_t ch);
        lvds_rx_pkg::video_sync_t sy;
        sy.de = ch.lane2[0];
        sy.vs = ch.lane2[1];
        sy.hs = ch.lane2[2];
        return sy;
    endfunction

    // --------------------
    // stimulus
    // --------------------

    // one clock of random data plus its expected result two cycles later
    task automatic step();
        logic [31:0]                 rnd_a;
        logic [31:0]                 rnd_b;
        lvds_rx_pkg::channel_lanes_t al_odd;
        lvds_rx_pkg::channel_lanes_t al_even;
        expect_t                     e;
        @(posedge O_pix_clk);
        #1;
        rnd_a      = $urandom;
        rnd_b      = $urandom;
        al_odd     = pack_channel(rnd_a[23:0], rnd_a[26:24], map_mode, rnd_a[27]);
        al_even    = pack_channel(rnd_b[23:0], rnd_b[26:24], map_mode, rnd_b[27]);
        clk_word   = rotate_right(`LVDS_CLOCK_PATTERN, skew);
        lanes_odd  = skew_channel(al_odd, skew);
        lanes_even = skew_channel(al_even, skew);
        e.check    = (check_mode != CHK_NONE);
        e.odd      = '0;
        e.even     = '0;
        e.sync     = '0;
        if (check_mode == CHK_REF)
        begin
            e.odd  = unpack_ref(al_odd, map_mode);
            e.even = unpack_ref(al_even, map_mode);
            e.sync = sync_ref(al_even);
        end
        exp_q.push_back(e);
    endtask

    task automatic wait_for(input wait_cond_t cond, input int limit);
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && n < limit)
        begin
            step();
            n++;
            case (cond)
                W_LOCK:   done = word_lock;
                W_UNLOCK: done = !word_lock;
                default:  done = (pixel_odd == '0) && (pixel_even == '0) && (sync == '0);
            endcase
        end
        if (!done)
        begin
            timeouts++;
            $display("timeout: %s not reached within %0d cycles at skew %0d",
                     cond.name(), limit, skew);
        end
    endtask

    task automatic check_idle();
        checks++;
        if (word_lock !== 1'b0 || rotation !== '0)
        begin
            errors++;
            $display("[ERROR] %0d ns: idle with word_lock %b rotation %0d, expected 0 and 0",
                     $time, word_lock, rotation);
        end
    endtask

    task automatic run_sequence();
        for (int m = 0; m < 2; m++)
        begin
            map_mode = (m == 0) ? lvds_rx_pkg::MAP_VESA : lvds_rx_pkg::MAP_JEIDA;
            for (int k = 0; k < `LVDS_WORD_BITS; k++)
            begin
                skew       = k;
                check_mode = CHK_NONE;
                pll_lock   = 1'b1;
                phase_lock = 1'b1;
                wait_for(W_LOCK, LOCK_BOUND);
                if (timeouts != 0)
                    return;
                checks++;
                if (rotation !== lvds_rx_pkg::rotation_t'(k))
                begin
                    errors++;
                    $display("[ERROR] %0d ns: rotation %0d, expected %0d", $time, rotation, k);
                end
                check_mode = CHK_REF;
                repeat (DATA_CYCLES)
                    step();
                // phase lock lost while locked
                check_mode = CHK_NONE;
                phase_lock = 1'b0;
                wait_for(W_UNLOCK, 6);
                if (timeouts != 0)
                    return;
                wait_for(W_BLANK, 4);
                if (timeouts != 0)
                    return;
                check_mode = CHK_ZERO;
                pll_lock   = 1'b0;
                phase_lock = 1'b1;
                repeat (6)
                begin
                    step();
                    check_idle();
                end
                phase_lock = 1'b0;
            end
        end
    endtask

    // --------------------
    // output compare
    // --------------------

    always @(negedge O_pix_clk)
    begin : compare_outputs
        expect_t e;
        if (exp_q.size() > 2)
        begin
            e = exp_q.pop_front();
            if (e.check)
            begin
                cmp_checks++;
                if (pixel_odd !== e.odd)
                begin
                    cmp_errors++;
                    $display("[ERROR] %0d ns: pixel_odd %06h, expected %06h",
                             $time, pixel_odd, e.odd);
                end
                if (pixel_even !== e.even)
                begin
                    cmp_errors++;
                    $display("[ERROR] %0d ns: pixel_even %06h, expected %06h",
                             $time, pixel_even, e.even);
                end
                if (sync !== e.sync)
                begin
                    cmp_errors++;
                    $display("[ERROR] %0d ns: sync %03b, expected %03b", $time, sync, e.sync);
                end
            end
        end
    end

    initial
    begin
        O_pix_clk  = 1'b0;
        reset_sync = 1'b1;
        pll_lock   = 1'b0;
        phase_lock = 1'b0;
        map_mode   = lvds_rx_pkg::MAP_VESA;
        clk_word   = '0;
        lanes_odd  = '0;
        lanes_even = '0;
        check_mode = CHK_ZERO;
        skew       = 0;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        cmp_checks = 0;
        cmp_errors = 0;
        void'($urandom(25));
        repeat (16)
            step();
        reset_sync = 1'b0;
        pll_lock   = 1'b1;  // phase still low
        repeat (8)
        begin
            step();
            check_idle();
        end
        pll_lock = 1'b0;
        run_sequence();
        $display("checks %0d, errors %0d, timeouts %0d",
                 checks + cmp_checks, errors + cmp_errors, timeouts);
        if (errors == 0 && cmp_errors == 0 && timeouts == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/lvds_rx_pkg.sv
hdl/word_align_ctl.sv
hdl/lane_derotate.sv
hdl/pixel_unpack.sv
hdl/lvds_rx_top.sv
dv/lvds_rx_tb.sv

/* Makefile */
# Verilator build for the lvds receiver back end testbench

VERILATOR ?= verilator
TOP       ?= lvds_rx_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
SEED      ?= 25
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass message shows up on a line of its own
run: compile
	@out="$$(./$(SIM_BIN) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
